// ==== imem_pkg.sv ====
package imem_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Memory and serial sizes
    ////////////////////////////////////////////////////////////////////////////

    // Program store, one byte per address
    localparam int MEM_BYTES = 64;
    localparam int ADDR_W = 6;

    // Serial bit period in clk cycles
    localparam int CLKS_PER_BIT = 16;
    // Width of the bit period counter
    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    ////////////////////////////////////////////////////////////////////////////
    // RAM bus masters
    ////////////////////////////////////////////////////////////////////////////

    localparam int N_MASTERS = 2;
    // Lower index wins the arbitration
    localparam int M_LDR = 0;
    localparam int M_FCH = 1;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction word
    ////////////////////////////////////////////////////////////////////////////

    // RV32 base register layout, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_fields_t;

    // Same 32 bits, either as bytes or as decoded fields
    typedef union packed {
        // bytes[0] is the byte at the PC (little-endian)
        logic [3:0][7:0] bytes;
        instr_fields_t fields;
    } instr_t;

endpackage

// ==== mem_bus_if.sv ====
`timescale 1ns/10ps

interface mem_bus_if
    import imem_pkg::*;
();

    // Request side, held by the master until gnt
    logic req;
    logic we;
    logic [ADDR_W-1:0] addr;
    logic [7:0] wdata;

    // Combinational grant from the arbiter
    logic gnt;
    // Read data, valid one cycle after a granted read
    logic [7:0] rdata;

    modport master (
        output req,
        output we,
        output addr,
        output wdata,
        input gnt,
        input rdata
    );

    modport arbiter (
        input req,
        input we,
        input addr,
        input wdata,
        output gnt,
        output rdata
    );

endinterface

// ==== uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx
    import imem_pkg::*;
(
    input logic clk,
    input logic arst_n,
    input logic rx,
    output logic [7:0] data,
    output logic byte_valid
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP
    } rx_state_t;

    rx_state_t state;
    // Two-flop synchronizer plus one delay for the edge detect
    logic rx_s1;
    logic rx_s2;
    logic rx_d;
    logic [CNT_W-1:0] tick_cnt;
    logic [2:0] bit_idx;
    logic [7:0] shift_q;

    // Falling edge on the idle-high line marks a start bit
    logic start_edge;
    assign start_edge = rx_d & ~rx_s2;

    // Byte stays put in the shifter until the next frame's first data bit
    assign data = shift_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_s1 <= 1'b1;
            rx_s2 <= 1'b1;
            rx_d <= 1'b1;
            state <= S_IDLE;
            tick_cnt <= '0;
            bit_idx <= '0;
            byte_valid <= 1'b0;
        end else begin
            rx_s1 <= rx;
            rx_s2 <= rx_s1;
            rx_d <= rx_s2;
            byte_valid <= 1'b0;
            tick_cnt <= tick_cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    tick_cnt <= '0;
                    if (start_edge) begin
                        state <= S_START;
                    end
                end
                // Wait half a bit, then confirm the start is still low
                S_START: begin
                    if (tick_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                        tick_cnt <= '0;
                        bit_idx <= '0;
                        state <= rx_s2 ? S_IDLE : S_DATA;
                    end
                end
                // Sample each data bit at mid-bit, LSB first
                S_DATA: begin
                    if (tick_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        shift_q <= {rx_s2, shift_q[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= S_STOP;
                        end
                    end
                end
                // Good stop bit gives the strobe, a low one drops the byte
                S_STOP: begin
                    if (tick_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        byte_valid <= rx_s2;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== boot_loader.sv ====
`timescale 1ns/10ps

module boot_loader
    import imem_pkg::*;
(
    input logic clk,
    input logic arst_n,
    input logic [7:0] data,
    input logic byte_valid,
    mem_bus_if.master bus,
    output logic boot_done
);

    // Next RAM address to fill, starting at 0
    logic [ADDR_W-1:0] wr_addr;
    // Write waiting for its grant
    logic pending;
    logic [7:0] wr_byte;

    logic last_byte;
    assign last_byte = (wr_addr == ADDR_W'(MEM_BYTES - 1));

    // Loader only ever writes
    assign bus.req = pending;
    assign bus.we = pending;
    assign bus.addr = wr_addr;
    assign bus.wdata = wr_byte;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_addr <= '0;
            pending <= 1'b0;
            boot_done <= 1'b0;
        end else begin
            // Bytes after boot done are ignored
            if (byte_valid && !boot_done) begin
                pending <= 1'b1;
            end
            if (pending && bus.gnt) begin
                pending <= 1'b0;
                wr_addr <= wr_addr + 1'b1;
                if (last_byte) begin
                    boot_done <= 1'b1;
                end
            end
        end
    end

    // Payload copy of the received byte
    always_ff @(posedge clk) begin
        if (byte_valid && !boot_done) begin
            wr_byte <= data;
        end
    end

    // Byte period is far longer than a write, so no overrun
    a_no_overrun: assert property (@(posedge clk) disable iff (!arst_n)
        byte_valid |-> !pending)
        else $error("boot_loader: byte arrived with a write still pending");

endmodule

// ==== mem_arbiter.sv ====
`timescale 1ns/10ps

module mem_arbiter
    import imem_pkg::*;
(
    input logic clk,
    input logic arst_n,
    mem_bus_if.arbiter ldr,
    mem_bus_if.arbiter fch,
    output logic ram_en,
    output logic ram_we,
    output logic [ADDR_W-1:0] ram_addr,
    output logic [7:0] ram_wdata,
    input logic [7:0] ram_rdata
);

    ////////////////////////////////////////////////////////////////////////////
    // Fixed priority grant
    ////////////////////////////////////////////////////////////////////////////

    logic [N_MASTERS-1:0] gnt;

    // Loader always wins
    assign gnt[M_LDR] = ldr.req;
    assign gnt[M_FCH] = fch.req & ~ldr.req;

    assign ldr.gnt = gnt[M_LDR];
    assign fch.gnt = gnt[M_FCH];

    ////////////////////////////////////////////////////////////////////////////
    // RAM port mux
    ////////////////////////////////////////////////////////////////////////////

    assign ram_en = |gnt;
    assign ram_we = (gnt[M_LDR] & ldr.we) | (gnt[M_FCH] & fch.we);
    assign ram_addr = gnt[M_LDR] ? ldr.addr : fch.addr;
    assign ram_wdata = gnt[M_LDR] ? ldr.wdata : fch.wdata;

    // Read data goes to both, only the granted master takes it
    assign ldr.rdata = ram_rdata;
    assign fch.rdata = ram_rdata;

    a_one_grant: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(gnt))
        else $error("mem_arbiter: both masters granted");

    // Fetch must hold its read while the loader owns the RAM
    a_fch_hold: assert property (@(posedge clk) disable iff (!arst_n)
        fch.req && !fch.gnt |=> fch.req && $stable(fch.addr))
        else $error("mem_arbiter: fetch request dropped before grant");

endmodule

// ==== byte_ram.sv ====
`timescale 1ns/10ps

module byte_ram
    import imem_pkg::*;
(
    input logic clk,
    input logic en,
    input logic we,
    input logic [ADDR_W-1:0] addr,
    input logic [7:0] wdata,
    output logic [7:0] rdata
);

    // Program storage
    logic [7:0] mem [MEM_BYTES];

    // Single port, write or registered read per enabled cycle
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// ==== instr_fetch.sv ====
`timescale 1ns/10ps

module instr_fetch
    import imem_pkg::*;
(
    input logic clk,
    input logic arst_n,
    input logic fetch_req,
    input logic [ADDR_W-1:0] pc,
    mem_bus_if.master bus,
    output logic fetch_busy,
    output logic instr_valid,
    output logic [31:0] instr,
    output logic [6:0] opcode,
    output logic [4:0] rd,
    output logic [2:0] funct3,
    output logic [4:0] rs1,
    output logic [4:0] rs2,
    output logic [6:0] funct7
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_DONE
    } fetch_state_t;

    fetch_state_t state;
    logic [ADDR_W-1:0] base_pc;
    // Reads granted so far, 0 to 4
    logic [2:0] rd_idx;
    // Bytes returned so far
    logic [1:0] rx_idx;
    // A read was granted last cycle, its data is on rdata now
    logic rd_pend;
    instr_t word_q;
    instr_t word_nxt;
    instr_t out_q;
    logic last_rx;

    ////////////////////////////////////////////////////////////////////////////
    // Bus side
    ////////////////////////////////////////////////////////////////////////////

    // Next read overlaps the data return of the previous one
    assign bus.req = (state == S_RUN) && !rd_idx[2];
    assign bus.we = 1'b0;
    assign bus.wdata = '0;
    // Wraps at the top of the RAM, no alignment check
    assign bus.addr = base_pc + ADDR_W'(rd_idx[1:0]);

    // Merge the returning byte into the little-endian word
    always_comb begin
        word_nxt = word_q;
        if (rd_pend) begin
            word_nxt.bytes[rx_idx] = bus.rdata;
        end
    end

    assign last_rx = rd_pend && (rx_idx == 2'd3);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
            rd_idx <= '0;
            rx_idx <= '0;
            rd_pend <= 1'b0;
            instr_valid <= 1'b0;
            out_q <= '0;
        end else begin
            rd_pend <= bus.req && bus.gnt;
            instr_valid <= 1'b0;
            if (bus.req && bus.gnt) begin
                rd_idx <= rd_idx + 1'b1;
            end
            if (rd_pend) begin
                rx_idx <= rx_idx + 1'b1;
            end
            case (state)
                // Requests are only taken here, busy ones are dropped
                S_IDLE: begin
                    if (fetch_req) begin
                        state <= S_RUN;
                        rd_idx <= '0;
                        rx_idx <= '0;
                    end
                end
                S_RUN: begin
                    if (last_rx) begin
                        out_q <= word_nxt;
                        instr_valid <= 1'b1;
                        state <= S_DONE;
                    end
                end
                // Valid cycle, busy still high
                S_DONE: state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // Capture PC and collect bytes
    always_ff @(posedge clk) begin
        if (state == S_IDLE && fetch_req) begin
            base_pc <= pc;
        end
        word_q <= word_nxt;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////////////////////

    assign fetch_busy = (state != S_IDLE);
    assign instr = out_q.bytes;
    assign opcode = out_q.fields.opcode;
    assign rd = out_q.fields.rd;
    assign funct3 = out_q.fields.funct3;
    assign rs1 = out_q.fields.rs1;
    assign rs2 = out_q.fields.rs2;
    assign funct7 = out_q.fields.funct7;

    a_valid_busy: assert property (@(posedge clk) disable iff (!arst_n)
        instr_valid |-> fetch_busy)
        else $error("instr_fetch: instr_valid outside a fetch");

endmodule

// ==== imem_top.sv ====
`timescale 1ns/10ps

module imem_top
    import imem_pkg::*;
(
    input logic clk,
    input logic arst_n,
    input logic rx,
    input logic fetch_req,
    input logic [ADDR_W-1:0] pc,
    output logic boot_done,
    output logic fetch_busy,
    output logic instr_valid,
    output logic [31:0] instr,
    output logic [6:0] opcode,
    output logic [4:0] rd,
    output logic [2:0] funct3,
    output logic [4:0] rs1,
    output logic [4:0] rs2,
    output logic [6:0] funct7
);

    // Receiver to loader
    logic [7:0] rx_data;
    logic rx_valid;

    // Arbiter to RAM
    logic ram_en;
    logic ram_we;
    logic [ADDR_W-1:0] ram_addr;
    logic [7:0] ram_wdata;
    logic [7:0] ram_rdata;

    // One bus per master
    mem_bus_if ldr_bus ();
    mem_bus_if fch_bus ();

    ////////////////////////////////////////////////////////////////////////////
    // Load path
    ////////////////////////////////////////////////////////////////////////////

    uart_rx u_uart_rx (
        .clk        (clk),
        .arst_n     (arst_n),
        .rx         (rx),
        .data       (rx_data),
        .byte_valid (rx_valid)
    );

    boot_loader u_boot_loader (
        .clk        (clk),
        .arst_n     (arst_n),
        .data       (rx_data),
        .byte_valid (rx_valid),
        .bus        (ldr_bus.master),
        .boot_done  (boot_done)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Shared RAM and fetch path
    ////////////////////////////////////////////////////////////////////////////

    mem_arbiter u_mem_arbiter (
        .clk       (clk),
        .arst_n    (arst_n),
        .ldr       (ldr_bus.arbiter),
        .fch       (fch_bus.arbiter),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    byte_ram u_byte_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    instr_fetch u_instr_fetch (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_req   (fetch_req),
        .pc          (pc),
        .bus         (fch_bus.master),
        .fetch_busy  (fetch_busy),
        .instr_valid (instr_valid),
        .instr       (instr),
        .opcode      (opcode),
        .rd          (rd),
        .funct3      (funct3),
        .rs1         (rs1),
        .rs2         (rs2),
        .funct7      (funct7)
    );

endmodule

// ==== tb_imem.sv ====
`timescale 1ns/10ps

module tb_imem
    import imem_pkg::*;
();

    // Vector storage, wider than a byte so unused slots stand out
    localparam int MAX_VEC = 128;
    localparam int GAP_MAX = 40;
    localparam int FETCH_CYC = 20;

    logic clk;
    logic arst_n;
    logic rx;
    logic fetch_req;
    logic [ADDR_W-1:0] pc;
    logic boot_done;
    logic fetch_busy;
    logic instr_valid;
    logic [31:0] instr;
    logic [6:0] opcode;
    logic [4:0] rd;
    logic [2:0] funct3;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [6:0] funct7;

    logic [15:0] vec [MAX_VEC];
    // Reference copy of the program
    logic [7:0] prog [MEM_BYTES];
    logic [ADDR_W-1:0] fetch_pc [MAX_VEC];
    int n_fetch;
    logic [31:0] rng;
    int err_value;
    int err_ctrl;
    int accepted;
    int extra_reqs;
    int valid_cnt;
    int cycle_cnt;
    int cycle_limit;

    imem_top u_imem_top (
        .clk         (clk),
        .arst_n      (arst_n),
        .rx          (rx),
        .fetch_req   (fetch_req),
        .pc          (pc),
        .boot_done   (boot_done),
        .fetch_busy  (fetch_busy),
        .instr_valid (instr_valid),
        .instr       (instr),
        .opcode      (opcode),
        .rd          (rd),
        .funct3      (funct3),
        .rs1         (rs1),
        .rs2         (rs2),
        .funct7      (funct7)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // Run limit, armed once the vector count is known
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Count valid pulses away from the active edge
    always @(negedge clk) begin
        if (arst_n && instr_valid) begin
            valid_cnt++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Bytes pc..pc+3 wrapping at the top, little-endian
    function automatic logic [31:0] expected_word(input logic [ADDR_W-1:0] at);
        logic [ADDR_W-1:0] p;
        logic [31:0] w;
        w = '0;
        for (int k = 0; k < 4; k++) begin
            p = at + ADDR_W'(k);
            w[8*k +: 8] = prog[p];
        end
        return w;
    endfunction

    // One cycle, inputs change 1 ns after the edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) step();
    endtask

    task automatic check_eq(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
        assert (got == exp) else begin
            err_value++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // 8N1 frame, LSB first
    task automatic send_byte(input logic [7:0] b);
        rx = 1'b0;
        idle_cycles(CLKS_PER_BIT);
        for (int i = 0; i < 8; i++) begin
            rx = b[i];
            idle_cycles(CLKS_PER_BIT);
        end
        rx = 1'b1;
        idle_cycles(CLKS_PER_BIT);
    endtask

    task automatic load_program();
        int waited;
        for (int i = 0; i < MEM_BYTES; i++) begin
            check_eq($sformatf("boot_done before byte %0d", i), 32'(boot_done), 32'd0);
            rng = xorshift32(rng);
            idle_cycles(int'(rng % 32'(GAP_MAX + 1)));
            send_byte(prog[i]);
        end
        // Last write lands a few cycles after the stop bit is sampled
        waited = 0;
        while (!boot_done && waited < 2 * CLKS_PER_BIT) begin
            step();
            waited++;
        end
        assert (boot_done) else begin
            err_ctrl++;
            $display("boot_done never rose after the last program byte");
        end
    endtask

    task automatic run_fetch(input logic [ADDR_W-1:0] at);
        logic [31:0] exp_w;
        int waited;
        exp_w = expected_word(at);
        check_eq($sformatf("fetch_busy before fetch at pc %0d", at), 32'(fetch_busy), 32'd0);
        pc = at;
        fetch_req = 1'b1;
        step();
        fetch_req = 1'b0;
        accepted++;
        waited = 0;
        while (!instr_valid && waited < FETCH_CYC) begin
            // Stray requests while busy must be dropped
            rng = xorshift32(rng);
            if (fetch_busy && rng[1:0] == 2'd0) begin
                pc = rng[ADDR_W+1:2];
                fetch_req = 1'b1;
                extra_reqs++;
            end
            step();
            fetch_req = 1'b0;
            waited++;
        end
        assert (instr_valid) else begin
            err_ctrl++;
            $display("No instr_valid within %0d cycles of the fetch at pc %0d", FETCH_CYC, at);
        end
        check_eq($sformatf("instr at pc %0d", at), instr, exp_w);
        check_eq($sformatf("opcode at pc %0d", at), 32'(opcode), 32'(exp_w[6:0]));
        check_eq($sformatf("rd at pc %0d", at), 32'(rd), 32'(exp_w[11:7]));
        check_eq($sformatf("funct3 at pc %0d", at), 32'(funct3), 32'(exp_w[14:12]));
        check_eq($sformatf("rs1 at pc %0d", at), 32'(rs1), 32'(exp_w[19:15]));
        check_eq($sformatf("rs2 at pc %0d", at), 32'(rs2), 32'(exp_w[24:20]));
        check_eq($sformatf("funct7 at pc %0d", at), 32'(funct7), 32'(exp_w[31:25]));
        step();
        // Single-cycle pulse
        check_eq($sformatf("instr_valid after pc %0d", at), 32'(instr_valid), 32'd0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        rx = 1'b1;
        fetch_req = 1'b0;
        pc = '0;
        rng = 32'hee03;
        err_value = 0;
        err_ctrl = 0;
        accepted = 0;
        extra_reqs = 0;
        valid_cnt = 0;
        cycle_cnt = 0;
        n_fetch = 0;

        // Bit 15 marks a slot the file did not fill
        for (int i = 0; i < MAX_VEC; i++) begin
            vec[i] = 16'h8000 | 16'(i);
        end
        $readmemh("imem_vectors.txt", vec);
        for (int i = 0; i < MEM_BYTES; i++) begin
            assert (!vec[i][15]) else begin
                err_ctrl++;
                $display("Vectors file is missing program byte %0d", i);
            end
            prog[i] = vec[i][7:0];
        end
        while (MEM_BYTES + n_fetch < MAX_VEC && !vec[MEM_BYTES + n_fetch][15]) begin
            fetch_pc[n_fetch] = vec[MEM_BYTES + n_fetch][ADDR_W-1:0];
            n_fetch++;
        end
        assert (n_fetch > 0) else begin
            err_ctrl++;
            $display("Vectors file holds no fetch addresses");
        end
        cycle_limit = 2 * (MEM_BYTES * 10 * CLKS_PER_BIT + MEM_BYTES * GAP_MAX
                           + n_fetch * FETCH_CYC);

        // Reset for 3 cycles
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_eq("boot_done after reset", 32'(boot_done), 32'd0);
        check_eq("fetch_busy after reset", 32'(fetch_busy), 32'd0);
        check_eq("instr_valid after reset", 32'(instr_valid), 32'd0);
        check_eq("instr after reset", instr, 32'd0);

        load_program();

        for (int f = 0; f < n_fetch; f++) begin
            rng = xorshift32(rng);
            idle_cycles(int'(rng[1:0]));
            run_fetch(fetch_pc[f]);
        end

        idle_cycles(10);
        check_eq("instr_valid pulse count", 32'(valid_cnt), 32'(accepted));
        $display("Fetches: %0d accepted, %0d ignored while busy", accepted, extra_reqs);
        $display("Errors: %0d value, %0d control, %0d total",
                 err_value, err_ctrl, err_value + err_ctrl);
        if (err_value + err_ctrl == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== imem_vectors.txt ====
// Lines 1..8: 64 program bytes in hex, address 0 first, two RV32 words per line
// Then one fetch PC in hex per line
93 00 50 00  13 01 a0 00  // addi x1 / addi x2
b3 81 20 00  33 02 11 40  // add x3 / sub x4
b3 f2 20 00  33 e3 20 00  // and x5 / or x6
b3 c3 20 00  33 94 20 00  // xor x7 / sll x8
83 a4 41 00  23 a4 91 00  // lw x9 / sw x9
63 84 20 00  37 55 34 12  // beq / lui x10
97 15 00 00  ef 00 00 01  // auipc x11 / jal x1
33 a6 20 00  b3 56 11 40  // slt x12 / sra x13
// Aligned fetches
00
04
08
0c
28
3c
// Wrapping fetch, bytes 62 63 0 1
3e
// Unaligned fetches
01
07
3f
1d
20

// ==== build.f ====
imem_pkg.sv
mem_bus_if.sv
uart_rx.sv
boot_loader.sv
mem_arbiter.sv
byte_ram.sv
instr_fetch.sv
imem_top.sv
tb_imem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_imem
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard *.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then echo "No result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
